// File: build.f
+incdir+src
src/rs_pkg.sv
src/rs_dispatch_decode.sv
src/rs_bank.sv
src/rs_issue_arbiter.sv
src/reservation_station.sv
tb/rs_clock_gen.sv
tb/rs_assertions.sv
tb/rs_tb.sv

// File: run.sh
#!/bin/sh
# build the reservation station testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module rs_tb \
    -f build.f -o rs_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

# keep running past assertion errors so the testbench can report them at the end
./obj_dir/rs_tb_sim +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: tb/rs_tb.sv
`include "rs_cfg.svh"

module rs_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rs_pkg::*;

    localparam int        TIMEOUT_CYCLES = 2000; // tests take about 300
    localparam dispatch_t NO_DISP        = '0;
    localparam cdb_t      NO_CDB         = '0;

    typedef struct {
        int         alu_idx;
        int         mul_idx;
        logic       alu_valid;
        logic       mul_valid;
        alu_issue_t alu_issue;
        mul_issue_t mul_issue;
        logic       alu_full;
        logic       mul_full;
    } expect_t;

    logic       clk;
    logic       rst;
    dispatch_t  dispatch;
    cdb_t       cdb_alu;
    cdb_t       cdb_mul;
    logic       alu_busy;
    logic       mul_busy;
    logic       alu_issue_valid;
    alu_issue_t alu_issue;
    logic       mul_issue_valid;
    mul_issue_t mul_issue;
    logic       alu_full;
    logic       mul_full;

    // model of both stations
    logic [`RS_ALU_DEPTH-1:0] m_alu_busy = '0;
    logic [`RS_ALU_DEPTH-1:0] m_alu_rdy1;
    logic [`RS_ALU_DEPTH-1:0] m_alu_rdy2;
    src_tags_t                m_alu_tags [`RS_ALU_DEPTH];
    alu_payload_t             m_alu_pay  [`RS_ALU_DEPTH];
    logic [`RS_MUL_DEPTH-1:0] m_mul_busy = '0;
    logic [`RS_MUL_DEPTH-1:0] m_mul_rdy1;
    logic [`RS_MUL_DEPTH-1:0] m_mul_rdy2;
    src_tags_t                m_mul_tags [`RS_MUL_DEPTH];
    mul_payload_t             m_mul_pay  [`RS_MUL_DEPTH];

    int unsigned cycles = 0;

    rs_clock_gen u_clock (
        .clk (clk),
        .rst (rst)
    );

    reservation_station i_dut (
        .clk             (clk),
        .rst             (rst),
        .dispatch        (dispatch),
        .cdb_alu         (cdb_alu),
        .cdb_mul         (cdb_mul),
        .alu_busy        (alu_busy),
        .mul_busy        (mul_busy),
        .alu_issue_valid (alu_issue_valid),
        .alu_issue       (alu_issue),
        .mul_issue_valid (mul_issue_valid),
        .mul_issue       (mul_issue),
        .alu_full        (alu_full),
        .mul_full        (mul_full)
    );

    bind reservation_station rs_assertions u_assert (
        .clk             (clk),
        .rst             (rst),
        .alu_issue_valid (alu_issue_valid),
        .mul_issue_valid (mul_issue_valid),
        .alu_busy        (alu_busy),
        .mul_busy        (mul_busy),
        .alu_full        (alu_full),
        .mul_full        (mul_full)
    );

    function automatic alu_op_t alu_op_of(logic [2:0] func);
        case (func)
            3'd0:    return ALU_ADD;
            3'd1:    return ALU_SUB;
            3'd2:    return ALU_AND;
            3'd3:    return ALU_OR;
            3'd4:    return ALU_XOR;
            3'd5:    return ALU_SLT;
            3'd6:    return ALU_SLL;
            default: return ALU_SRL;
        endcase
    endfunction

    function automatic mul_op_t mul_op_of(logic [2:0] func);
        case (func[1:0]) // top bit has no meaning for multiply
            2'd0:    return MUL_MUL;
            2'd1:    return MUL_MULH;
            2'd2:    return MUL_MULHU;
            default: return MUL_MULHSU;
        endcase
    endfunction

    function automatic logic broadcast_hit(preg_t tag);
        return (cdb_alu.valid && (cdb_alu.tag == tag)) || (cdb_mul.valid && (cdb_mul.tag == tag));
    endfunction

    function automatic dispatch_t make_disp(rs_kind_t kind, preg_t ps1, logic r1, preg_t ps2,
                                            logic r2, preg_t pd, logic [2:0] func);
        dispatch_t d;
        d.valid     = 1'b1;
        d.kind      = kind;
        d.ps1       = ps1;
        d.ps1_ready = r1;
        d.ps2       = ps2;
        d.ps2_ready = r2;
        d.pd        = pd;
        d.rd        = areg_t'(pd);
        d.rob       = rob_idx_t'(pd);
        d.func      = func;
        return d;
    endfunction

    function automatic cdb_t make_cdb(logic valid, preg_t tag);
        cdb_t c;
        c.valid = valid;
        c.tag   = tag;
        return c;
    endfunction

    // expected grants and packets for this cycle from model state and inputs
    function automatic expect_t expected_issue();
        expect_t e;
        int      slots;
        e.alu_idx = -1;
        e.mul_idx = -1;
        for (int i = 0; i < `RS_ALU_DEPTH; i++)
            if (e.alu_idx < 0 && m_alu_busy[i] && m_alu_rdy1[i] && m_alu_rdy2[i])
                e.alu_idx = i;
        for (int i = 0; i < `RS_MUL_DEPTH; i++)
            if (e.mul_idx < 0 && m_mul_busy[i] && m_mul_rdy1[i] && m_mul_rdy2[i])
                e.mul_idx = i;
        slots = `RS_MAX_ISSUES;
        e.mul_valid = (e.mul_idx >= 0) && !mul_busy && (slots > 0); // multiply first
        if (e.mul_valid)
            slots--;
        e.alu_valid = (e.alu_idx >= 0) && !alu_busy && (slots > 0);
        e.alu_issue = '0;
        e.mul_issue = '0;
        if (e.alu_valid)
        begin
            e.alu_issue.src     = m_alu_tags[e.alu_idx];
            e.alu_issue.payload = m_alu_pay[e.alu_idx];
        end
        if (e.mul_valid)
        begin
            e.mul_issue.src     = m_mul_tags[e.mul_idx];
            e.mul_issue.payload = m_mul_pay[e.mul_idx];
        end
        e.alu_full = &m_alu_busy;
        e.mul_full = &m_mul_busy;
        return e;
    endfunction

    task automatic advance_model(input expect_t e);
        logic [`RS_ALU_DEPTH-1:0] alu_start;
        logic [`RS_MUL_DEPTH-1:0] mul_start;
        int                       slot;
        alu_start = m_alu_busy;
        mul_start = m_mul_busy;
        for (int i = 0; i < `RS_ALU_DEPTH; i++)
        begin
            if (m_alu_busy[i] && broadcast_hit(m_alu_tags[i].ps1))
                m_alu_rdy1[i] = 1'b1;
            if (m_alu_busy[i] && broadcast_hit(m_alu_tags[i].ps2))
                m_alu_rdy2[i] = 1'b1;
        end
        for (int i = 0; i < `RS_MUL_DEPTH; i++)
        begin
            if (m_mul_busy[i] && broadcast_hit(m_mul_tags[i].ps1))
                m_mul_rdy1[i] = 1'b1;
            if (m_mul_busy[i] && broadcast_hit(m_mul_tags[i].ps2))
                m_mul_rdy2[i] = 1'b1;
        end
        if (e.alu_valid)
            m_alu_busy[e.alu_idx] = 1'b0;
        if (e.mul_valid)
            m_mul_busy[e.mul_idx] = 1'b0;
        // new entry goes to the lowest slot free at cycle start
        if (dispatch.valid && dispatch.kind == RS_ALU && !(&alu_start))
        begin
            slot = -1;
            for (int i = 0; i < `RS_ALU_DEPTH; i++)
                if (slot < 0 && !alu_start[i])
                    slot = i;
            m_alu_busy[slot]     = 1'b1;
            m_alu_rdy1[slot]     = dispatch.ps1_ready || broadcast_hit(dispatch.ps1);
            m_alu_rdy2[slot]     = dispatch.ps2_ready || broadcast_hit(dispatch.ps2);
            m_alu_tags[slot].ps1 = dispatch.ps1;
            m_alu_tags[slot].ps2 = dispatch.ps2;
            m_alu_pay[slot].pd   = dispatch.pd;
            m_alu_pay[slot].rd   = dispatch.rd;
            m_alu_pay[slot].rob  = dispatch.rob;
            m_alu_pay[slot].op   = alu_op_of(dispatch.func);
        end
        if (dispatch.valid && dispatch.kind == RS_MUL && !(&mul_start))
        begin
            slot = -1;
            for (int i = 0; i < `RS_MUL_DEPTH; i++)
                if (slot < 0 && !mul_start[i])
                    slot = i;
            m_mul_busy[slot]     = 1'b1;
            m_mul_rdy1[slot]     = dispatch.ps1_ready || broadcast_hit(dispatch.ps1);
            m_mul_rdy2[slot]     = dispatch.ps2_ready || broadcast_hit(dispatch.ps2);
            m_mul_tags[slot].ps1 = dispatch.ps1;
            m_mul_tags[slot].ps2 = dispatch.ps2;
            m_mul_pay[slot].pd   = dispatch.pd;
            m_mul_pay[slot].rd   = dispatch.rd;
            m_mul_pay[slot].rob  = dispatch.rob;
            m_mul_pay[slot].op   = mul_op_of(dispatch.func);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_alu_issue(input logic exp_valid, input alu_issue_t exp_issue,
                                   input logic got_valid, input alu_issue_t got_issue);
        if (got_valid !== exp_valid || (exp_valid && (got_issue !== exp_issue)))
        begin
            $display("Error at %0t: alu issue valid %0b data %h, expected valid %0b data %h",
                     $time, got_valid, got_issue, exp_valid, exp_issue);
            abort_run("alu issue mismatch");
        end
    endtask

    task automatic check_mul_issue(input logic exp_valid, input mul_issue_t exp_issue,
                                   input logic got_valid, input mul_issue_t got_issue);
        if (got_valid !== exp_valid || (exp_valid && (got_issue !== exp_issue)))
        begin
            $display("Error at %0t: mul issue valid %0b data %h, expected valid %0b data %h",
                     $time, got_valid, got_issue, exp_valid, exp_issue);
            abort_run("mul issue mismatch");
        end
    endtask

    task automatic check_full(input string station, input logic exp_full, input logic got_full);
        if (got_full !== exp_full)
        begin
            $display("Error at %0t: %s full flag %0b, expected %0b",
                     $time, station, got_full, exp_full);
            abort_run("full flag mismatch");
        end
    endtask

    // outputs settled since the falling edge and state moves after this
    always @(posedge clk)
    begin : compare
        expect_t e;
        if (rst)
        begin
            m_alu_busy = '0;
            m_mul_busy = '0;
        end
        else
        begin
            e = expected_issue();
            check_alu_issue(e.alu_valid, e.alu_issue, alu_issue_valid, alu_issue);
            check_mul_issue(e.mul_valid, e.mul_issue, mul_issue_valid, mul_issue);
            check_full("alu", e.alu_full, alu_full);
            check_full("mul", e.mul_full, mul_full);
            advance_model(e);
        end
    end

    // a failed bound assertion ends the run at once
    initial
    begin
        wait (i_dut.u_assert.fail_count != 0);
        abort_run("a bound assertion failed");
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            abort_run("timeout");
        end
    end

    task automatic drive(input dispatch_t d, input cdb_t ca, input cdb_t cm,
                         input logic ab, input logic mb);
        @(negedge clk);
        dispatch = d;
        cdb_alu  = ca;
        cdb_mul  = cm;
        alu_busy = ab;
        mul_busy = mb;
    endtask

    // idle with units free and sweep broadcast tags until both stations are empty
    task automatic drain();
        int n;
        n = 0;
        do
        begin
            drive(NO_DISP, make_cdb(1'b1, preg_t'(n)), NO_CDB, 1'b0, 1'b0);
            n++;
        end
        while (m_alu_busy != '0 || m_mul_busy != '0);
    endtask

    initial
    begin
        dispatch_t d;
        cdb_t      ca;
        cdb_t      cm;
        void'($urandom(32'h50e0_ac0f));
        dispatch = NO_DISP;
        cdb_alu  = NO_CDB;
        cdb_mul  = NO_CDB;
        alu_busy = 1'b0;
        mul_busy = 1'b0;
        @(negedge rst);

        // ready at dispatch so issue next cycle with decoded op
        drive(make_disp(RS_ALU, 6'd1, 1'b1, 6'd2, 1'b1, 6'd3, 3'd5), NO_CDB, NO_CDB, 1'b0, 1'b0);
        drive(make_disp(RS_MUL, 6'd4, 1'b1, 6'd5, 1'b1, 6'd6, 3'd6), NO_CDB, NO_CDB, 1'b0, 1'b0);
        drain();

        // wakeup but none from an invalid broadcast
        drive(make_disp(RS_ALU, 6'd10, 1'b0, 6'd2, 1'b1, 6'd11, 3'd1), NO_CDB, NO_CDB, 1'b0, 1'b0);
        drive(make_disp(RS_MUL, 6'd2, 1'b1, 6'd12, 1'b0, 6'd13, 3'd3), NO_CDB, NO_CDB, 1'b0, 1'b0);
        drive(NO_DISP, make_cdb(1'b0, 6'd10), make_cdb(1'b0, 6'd12), 1'b0, 1'b0);
        drive(NO_DISP, NO_CDB, NO_CDB, 1'b0, 1'b0);
        drive(NO_DISP, NO_CDB, make_cdb(1'b1, 6'd10), 1'b0, 1'b0);
        drive(NO_DISP, make_cdb(1'b1, 6'd12), NO_CDB, 1'b0, 1'b0);
        drain();

        // broadcast in the dispatch cycle
        drive(make_disp(RS_ALU, 6'd20, 1'b0, 6'd21, 1'b0, 6'd22, 3'd7),
              make_cdb(1'b1, 6'd20), make_cdb(1'b1, 6'd21), 1'b0, 1'b0);
        drain();

        // fill both stations behind busy units plus one extra dispatch each
        for (int i = 0; i < `RS_ALU_DEPTH + 1; i++)
            drive(make_disp(RS_ALU, 6'd1, 1'b1, 6'd2, 1'b1, preg_t'(30 + i), 3'(i)),
                  NO_CDB, NO_CDB, 1'b1, 1'b0);
        for (int i = 0; i < `RS_MUL_DEPTH + 1; i++)
            drive(make_disp(RS_MUL, 6'd1, 1'b1, 6'd2, 1'b1, preg_t'(40 + i), 3'(i + 4)),
                  NO_CDB, NO_CDB, 1'b1, 1'b1);
        drive(NO_DISP, NO_CDB, NO_CDB, 1'b1, 1'b1);
        drain();

        // both ready so multiply wins and then alu in index order
        drive(make_disp(RS_ALU, 6'd1, 1'b1, 6'd2, 1'b1, 6'd50, 3'd2), NO_CDB, NO_CDB, 1'b1, 1'b1);
        drive(make_disp(RS_ALU, 6'd1, 1'b1, 6'd2, 1'b1, 6'd51, 3'd3), NO_CDB, NO_CDB, 1'b1, 1'b1);
        drive(make_disp(RS_MUL, 6'd1, 1'b1, 6'd2, 1'b1, 6'd52, 3'd1), NO_CDB, NO_CDB, 1'b1, 1'b1);
        drain();

        repeat (200)
        begin
            d = NO_DISP;
            if ($urandom_range(1) == 1)
                d = make_disp(($urandom_range(1) == 1) ? RS_MUL : RS_ALU,
                              preg_t'($urandom_range(15)), $urandom_range(3) != 0,
                              preg_t'($urandom_range(15)), $urandom_range(3) != 0,
                              preg_t'($urandom_range(63)), 3'($urandom_range(7)));
            ca = make_cdb($urandom_range(1) == 1, preg_t'($urandom_range(15)));
            cm = make_cdb($urandom_range(1) == 1, preg_t'($urandom_range(15)));
            drive(d, ca, cm, $urandom_range(3) == 0, $urandom_range(3) == 0);
        end
        drain();
        repeat (2) drive(NO_DISP, NO_CDB, NO_CDB, 1'b0, 1'b0);

        $display("No errors");
        $finish;
    end

endmodule

// File: tb/rs_assertions.sv
`include "rs_cfg.svh"

module rs_assertions (
    input logic clk,
    input logic rst,
    input logic alu_issue_valid,
    input logic mul_issue_valid,
    input logic alu_busy,
    input logic mul_busy,
    input logic alu_full,
    input logic mul_full
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    issue_idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !alu_issue_valid && !mul_issue_valid)
    else
    begin
        fail_count++;
        $error("issue valid high in the first cycle after reset");
    end

    issue_limit: assert property (@(posedge clk) disable iff (rst)
        $countones({alu_issue_valid, mul_issue_valid}) <= `RS_MAX_ISSUES)
    else
    begin
        fail_count++;
        $error("more issues in one cycle than the issue limit");
    end

    // a busy unit never gets an instruction
    no_issue_when_busy: assert property (@(posedge clk)
        !(alu_issue_valid && alu_busy) && !(mul_issue_valid && mul_busy))
    else
    begin
        fail_count++;
        $error("issue valid while its unit is busy");
    end

    empty_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !alu_full && !mul_full)
    else
    begin
        fail_count++;
        $error("full flag high in the first cycle after reset");
    end

endmodule

// File: tb/rs_clock_gen.sv
module rs_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk; // 10 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // five rising edges seen with reset high
    end

endmodule

// File: src/reservation_station.sv
`include "rs_cfg.svh"

module reservation_station (
    input  logic               clk,
    input  logic               rst,
    input  rs_pkg::dispatch_t  dispatch,
    input  rs_pkg::cdb_t       cdb_alu,
    input  rs_pkg::cdb_t       cdb_mul,
    input  logic               alu_busy,
    input  logic               mul_busy,
    output logic               alu_issue_valid,
    output rs_pkg::alu_issue_t alu_issue,
    output logic               mul_issue_valid,
    output rs_pkg::mul_issue_t mul_issue,
    output logic               alu_full,
    output logic               mul_full
);
    import rs_pkg::*;

    // decoder to banks
    logic         alu_write;
    src_tags_t    alu_tags;
    logic         alu_rdy1;
    logic         alu_rdy2;
    alu_payload_t alu_payload;
    logic         mul_write;
    src_tags_t    mul_tags;
    logic         mul_rdy1;
    logic         mul_rdy2;
    mul_payload_t mul_payload;

    // banks to arbiter
    logic         alu_req;
    src_tags_t    alu_sel_tags;
    alu_payload_t alu_sel_payload;
    logic         mul_req;
    src_tags_t    mul_sel_tags;
    mul_payload_t mul_sel_payload;

    rs_dispatch_decode u_decode (
        .dispatch    (dispatch),
        .cdb_alu     (cdb_alu),
        .cdb_mul     (cdb_mul),
        .alu_write   (alu_write),
        .alu_tags    (alu_tags),
        .alu_rdy1    (alu_rdy1),
        .alu_rdy2    (alu_rdy2),
        .alu_payload (alu_payload),
        .mul_write   (mul_write),
        .mul_tags    (mul_tags),
        .mul_rdy1    (mul_rdy1),
        .mul_rdy2    (mul_rdy2),
        .mul_payload (mul_payload)
    );

    rs_bank #(
        .payload_t (alu_payload_t),
        .DEPTH     (`RS_ALU_DEPTH)
    ) u_alu_bank (
        .clk         (clk),
        .rst         (rst),
        .write       (alu_write),
        .tags        (alu_tags),
        .rdy1        (alu_rdy1),
        .rdy2        (alu_rdy2),
        .payload     (alu_payload),
        .cdb_alu     (cdb_alu),
        .cdb_mul     (cdb_mul),
        .grant       (alu_issue_valid), // issue valid is the grant
        .req         (alu_req),
        .sel_tags    (alu_sel_tags),
        .sel_payload (alu_sel_payload),
        .full        (alu_full)
    );

    rs_bank #(
        .payload_t (mul_payload_t),
        .DEPTH     (`RS_MUL_DEPTH)
    ) u_mul_bank (
        .clk         (clk),
        .rst         (rst),
        .write       (mul_write),
        .tags        (mul_tags),
        .rdy1        (mul_rdy1),
        .rdy2        (mul_rdy2),
        .payload     (mul_payload),
        .cdb_alu     (cdb_alu),
        .cdb_mul     (cdb_mul),
        .grant       (mul_issue_valid),
        .req         (mul_req),
        .sel_tags    (mul_sel_tags),
        .sel_payload (mul_sel_payload),
        .full        (mul_full)
    );

    rs_issue_arbiter u_arbiter (
        .alu_req         (alu_req),
        .alu_sel_tags    (alu_sel_tags),
        .alu_sel_payload (alu_sel_payload),
        .mul_req         (mul_req),
        .mul_sel_tags    (mul_sel_tags),
        .mul_sel_payload (mul_sel_payload),
        .alu_busy        (alu_busy),
        .mul_busy        (mul_busy),
        .alu_grant       (alu_issue_valid),
        .mul_grant       (mul_issue_valid),
        .alu_issue       (alu_issue),
        .mul_issue       (mul_issue)
    );

endmodule

// File: src/rs_issue_arbiter.sv
`include "rs_cfg.svh"

module rs_issue_arbiter (
    input  logic                 alu_req,
    input  rs_pkg::src_tags_t    alu_sel_tags,
    input  rs_pkg::alu_payload_t alu_sel_payload,
    input  logic                 mul_req,
    input  rs_pkg::src_tags_t    mul_sel_tags,
    input  rs_pkg::mul_payload_t mul_sel_payload,
    input  logic                 alu_busy,
    input  logic                 mul_busy,
    output logic                 alu_grant,
    output logic                 mul_grant,
    output rs_pkg::alu_issue_t   alu_issue,
    output rs_pkg::mul_issue_t   mul_issue
);

    int unsigned n_issued; // grants handed out so far this cycle

    // multiply goes first, then alu if a slot is left
    always_comb
    begin
        n_issued  = 0;
        mul_grant = 1'b0;
        alu_grant = 1'b0;

        if (mul_req && !mul_busy && (n_issued < `RS_MAX_ISSUES))
        begin
            mul_grant = 1'b1;
            n_issued  = n_issued + 1;
        end

        if (alu_req && !alu_busy && (n_issued < `RS_MAX_ISSUES))
        begin
            alu_grant = 1'b1;
            n_issued  = n_issued + 1;
        end
    end

    // packets follow the selected entry, qualified by the grant
    assign alu_issue.src     = alu_sel_tags;
    assign alu_issue.payload = alu_sel_payload;
    assign mul_issue.src     = mul_sel_tags;
    assign mul_issue.payload = mul_sel_payload;

endmodule

// File: src/rs_bank.sv
module rs_bank #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              write,
    input  rs_pkg::src_tags_t tags,
    input  logic              rdy1,
    input  logic              rdy2,
    input  payload_t          payload,
    input  rs_pkg::cdb_t      cdb_alu,
    input  rs_pkg::cdb_t      cdb_mul,
    input  logic              grant,
    output logic              req,
    output rs_pkg::src_tags_t sel_tags,
    output payload_t          sel_payload,
    output logic              full
);
    import rs_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // per entry control
    logic [DEPTH-1:0] busy_q;
    logic [DEPTH-1:0] rdy1_q;
    logic [DEPTH-1:0] rdy2_q;

    // per entry data
    src_tags_t tags_q    [DEPTH];
    payload_t  payload_q [DEPTH];

    logic [DEPTH-1:0] ready_vec;
    logic [IDX_W-1:0] sel_idx;
    logic [IDX_W-1:0] free_idx;
    logic             do_write;

    assign ready_vec = busy_q & rdy1_q & rdy2_q;
    assign do_write  = write && !full; // dispatch into a full bank is dropped

    // scanning downwards leaves the lowest match
    always_comb
    begin
        sel_idx  = '0;
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (ready_vec[i])
                sel_idx = IDX_W'(i);
            if (!busy_q[i])
                free_idx = IDX_W'(i);
        end
    end

    assign req         = |ready_vec;
    assign full        = &busy_q;
    assign sel_tags    = tags_q[sel_idx];
    assign sel_payload = payload_q[sel_idx];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q <= '0;
            rdy1_q <= '0;
            rdy2_q <= '0;
        end
        else
        begin
            // wakeup from this cycle's broadcasts
            for (int i = 0; i < DEPTH; i++)
            begin
                if (busy_q[i] && cdb_hit(cdb_alu, cdb_mul, tags_q[i].ps1))
                    rdy1_q[i] <= 1'b1;
                if (busy_q[i] && cdb_hit(cdb_alu, cdb_mul, tags_q[i].ps2))
                    rdy2_q[i] <= 1'b1;
            end

            if (grant)
                busy_q[sel_idx] <= 1'b0; // issued, slot free next cycle

            // free_idx was free at cycle start, never the granted slot
            if (do_write)
            begin
                busy_q[free_idx] <= 1'b1;
                rdy1_q[free_idx] <= rdy1;
                rdy2_q[free_idx] <= rdy2;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            tags_q[free_idx]    <= tags;
            payload_q[free_idx] <= payload;
        end
    end

endmodule

// File: src/rs_dispatch_decode.sv
module rs_dispatch_decode (
    input  rs_pkg::dispatch_t    dispatch,
    input  rs_pkg::cdb_t         cdb_alu,
    input  rs_pkg::cdb_t         cdb_mul,
    output logic                 alu_write,
    output rs_pkg::src_tags_t    alu_tags,
    output logic                 alu_rdy1,
    output logic                 alu_rdy2,
    output rs_pkg::alu_payload_t alu_payload,
    output logic                 mul_write,
    output rs_pkg::src_tags_t    mul_tags,
    output logic                 mul_rdy1,
    output logic                 mul_rdy2,
    output rs_pkg::mul_payload_t mul_payload
);
    import rs_pkg::*;

    src_tags_t tags;
    logic      rdy1;
    logic      rdy2;

    assign tags.ps1 = dispatch.ps1;
    assign tags.ps2 = dispatch.ps2;

    // a result on the bus this cycle counts as ready at dispatch
    assign rdy1 = dispatch.ps1_ready | cdb_hit(cdb_alu, cdb_mul, dispatch.ps1);
    assign rdy2 = dispatch.ps2_ready | cdb_hit(cdb_alu, cdb_mul, dispatch.ps2);

    assign alu_write = dispatch.valid && (dispatch.kind == RS_ALU);
    assign mul_write = dispatch.valid && (dispatch.kind == RS_MUL);

    assign alu_tags = tags;
    assign alu_rdy1 = rdy1;
    assign alu_rdy2 = rdy2;
    assign mul_tags = tags;
    assign mul_rdy1 = rdy1;
    assign mul_rdy2 = rdy2;

    always_comb
    begin
        alu_payload.pd  = dispatch.pd;
        alu_payload.rd  = dispatch.rd;
        alu_payload.rob = dispatch.rob;
        alu_payload.op  = alu_op_t'(dispatch.func); // one to one with the field

        mul_payload.pd  = dispatch.pd;
        mul_payload.rd  = dispatch.rd;
        mul_payload.rob = dispatch.rob;
        mul_payload.op  = mul_op_t'(dispatch.func[1:0]); // top bit ignored
    end

endmodule

// File: src/rs_pkg.sv
`include "rs_cfg.svh"

package rs_pkg;

    typedef logic [`RS_PREG_W-1:0] preg_t;
    typedef logic [`RS_AREG_W-1:0] areg_t;
    typedef logic [`RS_ROB_W-1:0]  rob_idx_t;

    typedef enum logic {
        RS_ALU = 1'b0,
        RS_MUL = 1'b1
    } rs_kind_t;

    // codes match the raw function field
    typedef enum logic [`RS_FUNC_W-1:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        MUL_MUL    = 2'd0,
        MUL_MULH   = 2'd1,
        MUL_MULHU  = 2'd2,
        MUL_MULHSU = 2'd3
    } mul_op_t; // low two function bits

    typedef struct packed {
        logic                  valid;
        rs_kind_t              kind;
        preg_t                 ps1;
        logic                  ps1_ready;
        preg_t                 ps2;
        logic                  ps2_ready;
        preg_t                 pd;
        areg_t                 rd;
        rob_idx_t              rob;
        logic [`RS_FUNC_W-1:0] func;
    } dispatch_t;

    typedef struct packed {
        logic  valid;
        preg_t tag;
    } cdb_t;

    typedef struct packed {
        preg_t ps1;
        preg_t ps2;
    } src_tags_t;

    typedef struct packed {
        preg_t    pd;
        areg_t    rd;
        rob_idx_t rob;
        alu_op_t  op;
    } alu_payload_t;

    typedef struct packed {
        preg_t    pd;
        areg_t    rd;
        rob_idx_t rob;
        mul_op_t  op;
    } mul_payload_t;

    typedef struct packed {
        src_tags_t    src;
        alu_payload_t payload;
    } alu_issue_t;

    typedef struct packed {
        src_tags_t    src;
        mul_payload_t payload;
    } mul_issue_t;

    // true when either broadcast of this cycle produces the tag
    function automatic logic cdb_hit(cdb_t cdb_alu, cdb_t cdb_mul, preg_t tag);
        return (cdb_alu.valid && (cdb_alu.tag == tag)) || (cdb_mul.valid && (cdb_mul.tag == tag));
    endfunction

endpackage

// File: src/rs_cfg.svh
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// tag and index widths
`define RS_PREG_W 6
`define RS_AREG_W 5
`define RS_ROB_W  6
`define RS_FUNC_W 3

// station sizes
`define RS_ALU_DEPTH 4
`define RS_MUL_DEPTH 2

`define RS_MAX_ISSUES 1 // issue slots per cycle, shared by both stations

`endif
